/* logic/aux_cfg.svh */
`ifndef AUX_CFG_SVH
`define AUX_CFG_SVH

// Field widths of one FIFO word
`define AUX_LINE_W 10
`define AUX_POS_W 16
`define AUX_SYM_W 9

// Power of two
`define AUX_FIFO_DEPTH 64

`define AUX_PKT_LEN 32

`endif

/* logic/video_timing_pkg.sv */
`default_nettype none
`include "aux_cfg.svh"

package video_timing_pkg;

  // Line number counted from frame start
  typedef logic [`AUX_LINE_W-1:0] line_t;

  typedef logic [`AUX_POS_W-1:0] pos_t;  // Cycles since active video ended

endpackage

`default_nettype wire

/* logic/aux_pkt_pkg.sv */
`default_nettype none
`include "aux_cfg.svh"

package aux_pkt_pkg;
  import video_timing_pkg::*;

  typedef logic [`AUX_SYM_W-1:0] sym_t;

  // One FIFO entry, 35 bits
  typedef struct packed {
    line_t line;   // Target line
    pos_t  start;  // Position of the first ade cycle
    sym_t  sym;
  } aux_word_t;

  typedef enum logic [1:0] {
    SEEK,
    BURST,
    FLUSH   // Discarding stale words
  } sched_state_t;

endpackage

`default_nettype wire

/* logic/blank_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module blank_tracker import video_timing_pkg::*; (
  input  logic  pclk,
  input  logic  rst,
  input  logic  vde,
  input  logic  frame_start,
  output pos_t  blank_pos,
  output line_t line_cnt
);

  logic vde_d;
  pos_t pos_q;  // Position of the current blank cycle

  always_ff @(posedge pclk) begin
    if (rst) begin
      vde_d <= 1'b0;
      pos_q <= '0;
    end else begin
      vde_d <= vde;
      if (vde)
        pos_q <= pos_t'(1);  // First blank cycle reads 1
      else
        pos_q <= pos_q + pos_t'(1);
    end
  end

  assign blank_pos = vde ? '0 : pos_q;

  // Completed active lines
  always_ff @(posedge pclk) begin
    if (rst)
      line_cnt <= '0;
    else if (frame_start)
      line_cnt <= '0;
    else if (vde_d && !vde)
      line_cnt <= line_cnt + line_t'(1);
  end

endmodule

`default_nettype wire

/* logic/aux_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "aux_cfg.svh"

module aux_fifo import aux_pkt_pkg::*; #(
  parameter int DEPTH = `AUX_FIFO_DEPTH
) (
  input  logic      pclk,
  input  logic      rst,
  input  logic      wr_en,
  input  aux_word_t wr_word,
  input  logic      rd_en,
  output aux_word_t head,
  output logic      empty,
  output logic      full
);

  localparam int AW = $clog2(DEPTH);

  aux_word_t   mem [DEPTH];
  logic [AW:0] wr_ptr;  // Extra bit tells full from empty
  logic [AW:0] rd_ptr;
  logic        push;
  logic        pop;

  assign push = wr_en && !full;  // Writes while full are lost
  assign pop  = rd_en && !empty;

  always_ff @(posedge pclk) begin
    if (push)
      mem[wr_ptr[AW-1:0]] <= wr_word;
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // First word falls through
  assign head = mem[rd_ptr[AW-1:0]];

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

`default_nettype wire

/* logic/aux_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module aux_scheduler import video_timing_pkg::*, aux_pkt_pkg::*; (
  input  logic      pclk,
  input  logic      rst,
  input  logic      vde,
  input  pos_t      blank_pos,
  input  line_t     line_cnt,
  input  aux_word_t head,
  input  logic      empty,
  input  logic      burst_last,
  output logic      rd_en,
  output logic      burst_start,
  output logic      burst_sym,
  output logic      drop
);

  sched_state_t state;
  sched_state_t state_nxt;
  logic         stale;
  logic         hit;

  // Head belongs to a line already passed
  assign stale = !empty && (head.line < line_cnt);

  // One cycle ahead, ade is registered downstream
  assign hit = !empty && !vde &&
               (head.line == line_cnt) &&
               (blank_pos + pos_t'(1) == head.start);

  assign burst_start = (state == SEEK) && hit;
  assign burst_sym   = burst_start || (state == BURST);
  assign drop        = ((state == SEEK) || (state == FLUSH)) && stale;

  // Underrun keeps the burst going but pops nothing
  assign rd_en = drop || (burst_sym && !empty);

  always_comb begin
    state_nxt = state;
    case (state)
      SEEK: begin
        if (stale)
          state_nxt = FLUSH;
        else if (hit)
          state_nxt = BURST;
      end
      BURST: begin
        // Next packet may start right in the following SEEK cycle
        if (burst_last)
          state_nxt = SEEK;
      end
      FLUSH: begin
        if (!stale)
          state_nxt = SEEK;  // Head current or FIFO drained
      end
      default: state_nxt = SEEK;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (rst)
      state <= SEEK;
    else
      state <= state_nxt;
  end

endmodule

`default_nettype wire

/* logic/island_out.sv */
`timescale 1ns/1ps
`default_nettype none
`include "aux_cfg.svh"

module island_out import aux_pkt_pkg::*; (
  input  logic pclk,
  input  logic rst,
  input  logic burst_start,
  input  logic burst_sym,
  input  logic drop,
  input  logic empty,
  input  sym_t head_sym,
  output logic burst_last,
  output logic ade,
  output sym_t aux_data,
  output logic aux_drop
);

  localparam logic [4:0] LAST_IDX = 5'(`AUX_PKT_LEN - 1);

  logic [4:0] sym_cnt;
  logic [4:0] sym_idx;  // Index of the symbol issued this cycle

  assign sym_idx    = burst_start ? 5'd0 : sym_cnt;
  assign burst_last = burst_sym && (sym_idx == LAST_IDX);

  always_ff @(posedge pclk) begin
    if (rst)
      sym_cnt <= '0;
    else if (burst_sym)
      sym_cnt <= sym_idx + 5'd1;
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      ade      <= 1'b0;
      aux_drop <= 1'b0;
    end else begin
      ade      <= burst_sym;
      aux_drop <= drop || (burst_sym && empty);  // Discard or underrun
    end
  end

  // Zero filler on underrun
  always_ff @(posedge pclk) begin
    aux_data <= (burst_sym && !empty) ? head_sym : '0;
  end

endmodule

`default_nettype wire

/* logic/aux_island_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "aux_cfg.svh"

module aux_island_top import video_timing_pkg::*, aux_pkt_pkg::*; (
  input  logic      pclk,
  input  logic      rst,
  input  logic      vde,
  input  logic      frame_start,
  input  logic      wr_en,
  input  aux_word_t wr_word,
  output logic      full,
  output logic      ade,
  output logic      aux_drop,
  output sym_t      aux_data
);

  pos_t      blank_pos;
  line_t     line_cnt;
  aux_word_t head;
  logic      empty;
  logic      rd_en;
  logic      burst_start;
  logic      burst_sym;
  logic      drop;
  logic      burst_last;

  blank_tracker u_tracker (
    .pclk        (pclk),
    .rst         (rst),
    .vde         (vde),
    .frame_start (frame_start),
    .blank_pos   (blank_pos),
    .line_cnt    (line_cnt)
  );

  aux_fifo #(.DEPTH(`AUX_FIFO_DEPTH)) u_fifo (
    .pclk    (pclk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_word (wr_word),
    .rd_en   (rd_en),
    .head    (head),
    .empty   (empty),
    .full    (full)
  );

  aux_scheduler u_sched (
    .pclk        (pclk),
    .rst         (rst),
    .vde         (vde),
    .blank_pos   (blank_pos),
    .line_cnt    (line_cnt),
    .head        (head),
    .empty       (empty),
    .burst_last  (burst_last),
    .rd_en       (rd_en),
    .burst_start (burst_start),
    .burst_sym   (burst_sym),
    .drop        (drop)
  );

  island_out u_island (
    .pclk        (pclk),
    .rst         (rst),
    .burst_start (burst_start),
    .burst_sym   (burst_sym),
    .drop        (drop),
    .empty       (empty),
    .head_sym    (head.sym),
    .burst_last  (burst_last),
    .ade         (ade),
    .aux_data    (aux_data),
    .aux_drop    (aux_drop)
  );

endmodule

`default_nettype wire

/* sim/aux_island_assertions.sv */
`timescale 1ns/1ps
`default_nettype none
`include "aux_cfg.svh"

module aux_island_assertions import aux_pkt_pkg::*; (
  input logic pclk,
  input logic rst,
  input logic vde,
  input logic ade,
  input logic aux_drop,
  input sym_t aux_data,
  input logic wr_en,
  input logic full,
  input logic rd_en
);

  logic       ade_q;
  logic [7:0] run_len;  // Length of the current ade run
  logic [7:0] occ;      // Words held, from accepted writes and pops

  always_ff @(posedge pclk) begin
    if (rst) begin
      ade_q   <= 1'b0;
      run_len <= '0;
      occ     <= '0;
    end else begin
      ade_q   <= ade;
      run_len <= ade ? run_len + 8'd1 : 8'd0;
      occ     <= occ + 8'(wr_en && !full) - 8'(rd_en);
    end
  end

  a_no_ade_in_video: assert property (@(posedge pclk) disable iff (rst) !(ade && vde))
    else $error("ade high during active video");

  // Chained packets give multiples of the packet length
  a_run_len: assert property (@(posedge pclk) disable iff (rst)
    (ade_q && !ade) |-> (run_len != 8'd0 && run_len % `AUX_PKT_LEN == 0))
    else $error("ade run length %0d", run_len);

  // Inside an island only underrun filler may raise aux_drop
  a_no_drop_in_burst: assert property (@(posedge pclk) disable iff (rst)
    (ade && aux_drop) |-> (aux_data == '0))
    else $error("discard inside a burst");

  a_no_pop_empty: assert property (@(posedge pclk) disable iff (rst) !(rd_en && occ == 8'd0))
    else $error("rd_en with empty FIFO");

endmodule

bind aux_island_top aux_island_assertions u_assert (
  .pclk     (pclk),
  .rst      (rst),
  .vde      (vde),
  .ade      (ade),
  .aux_drop (aux_drop),
  .aux_data (aux_data),
  .wr_en    (wr_en),
  .full     (full),
  .rd_en    (rd_en)
);

`default_nettype wire

/* sim/aux_island_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "aux_cfg.svh"

module aux_island_tb import video_timing_pkg::*, aux_pkt_pkg::*;;

  localparam int ACT = 200;
  localparam int BLANK = 100;
  localparam int VBLANK = 100;
  localparam int LINES = 8;
  localparam int FRAME_CYC = 1 + VBLANK + LINES * (ACT + BLANK);
  localparam int LIMIT = 9 * FRAME_CYC + 2000;  // About 8 frames of tests

  typedef struct packed {
    line_t line;
    pos_t  pos;
    sym_t  sym;
  } cap_t;

  logic      pclk;
  logic      rst;
  logic      vde;
  logic      frame_start;
  logic      wr_en;
  aux_word_t wr_word;
  logic      full;
  logic      ade;
  logic      aux_drop;
  sym_t      aux_data;

  cap_t   cap_q[$];
  cap_t   exp_q[$];
  int     drop_cnt;
  int     errors;
  int     tests;
  int     failed;
  int     cycle_cnt;
  integer seed;

  // Reference blanking position and line count
  pos_t  ref_q;
  pos_t  ref_pos;
  line_t ref_line;
  logic  ref_vde_d;

  aux_island_top DUT (
    .pclk(pclk), .rst(rst), .vde(vde), .frame_start(frame_start),
    .wr_en(wr_en), .wr_word(wr_word), .full(full), .ade(ade),
    .aux_drop(aux_drop), .aux_data(aux_data)
  );

  always #4 pclk = ~pclk;

  assign ref_pos = vde ? pos_t'(0) : ref_q;

  always @(posedge pclk) begin
    if (rst) begin
      ref_q     <= '0;
      ref_line  <= '0;
      ref_vde_d <= 1'b0;
    end else begin
      ref_q     <= vde ? pos_t'(1) : ref_q + pos_t'(1);
      ref_vde_d <= vde;
      if (frame_start)
        ref_line <= '0;
      else if (ref_vde_d && !vde)
        ref_line <= ref_line + line_t'(1);
    end
  end

  always @(negedge pclk) begin
    if (!rst) begin
      if (ade)
        cap_q.push_back('{line: ref_line, pos: ref_pos, sym: aux_data});
      if (aux_drop)
        drop_cnt++;
    end
  end

  always @(posedge pclk) begin
    cycle_cnt++;
    if (cycle_cnt >= LIMIT) begin
      $display("Timeout after %0d cycles, DUT output never completed", cycle_cnt);
      $display("Something failed");
      $finish;
    end
  end

  task automatic hold(input logic v, input logic fs, input int n);
    repeat (n) begin
      @(posedge pclk);
      #1;
      vde = v;
      frame_start = fs;
    end
  endtask

  task automatic video_loop();
    forever begin
      hold(1'b0, 1'b1, 1);
      hold(1'b0, 1'b0, VBLANK);
      repeat (LINES) begin
        hold(1'b1, 1'b0, ACT);
        hold(1'b0, 1'b0, BLANK);
      end
    end
  endtask

  task automatic wait_frame();
    do @(negedge pclk); while (!frame_start);
  endtask

  task automatic wait_blank(input line_t ln);
    do @(negedge pclk); while (!(ref_line == ln && !vde));
  endtask

  task automatic write_packet(input line_t ln, input pos_t st, input int n);
    sym_t s;
    for (int i = 0; i < n; i++) begin
      @(posedge pclk);
      #1;
      if (full !== 1'b0) begin
        $display("MISMATCH full: expected %h got %h", 1'b0, full);
        errors++;
      end
      s = sym_t'($random(seed));
      wr_en = 1'b1;
      wr_word = '{line: ln, start: st, sym: s};
      exp_q.push_back('{line: ln, pos: st + pos_t'(i), sym: s});
    end
    @(posedge pclk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic start_test();
    cap_q.delete();
    exp_q.delete();
    drop_cnt = 0;
  endtask

  task automatic check_output(input int drops);
    int n;
    if (cap_q.size() != exp_q.size()) begin
      $display("MISMATCH ade cycles: expected %h got %h", exp_q.size(), cap_q.size());
      errors++;
    end
    n = (cap_q.size() < exp_q.size()) ? cap_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      if (cap_q[i].line != exp_q[i].line || cap_q[i].pos != exp_q[i].pos) begin
        $display("MISMATCH line_cnt/blank_pos at ade %0d: expected %h/%h got %h/%h",
                 i, exp_q[i].line, exp_q[i].pos, cap_q[i].line, cap_q[i].pos);
        errors++;
      end
      if (cap_q[i].sym != exp_q[i].sym) begin
        $display("MISMATCH aux_data at ade %0d: expected %h got %h",
                 i, exp_q[i].sym, cap_q[i].sym);
        errors++;
      end
    end
    if (drop_cnt != drops) begin
      $display("MISMATCH aux_drop pulses: expected %h got %h", drops, drop_cnt);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: failed", name);
    end
  endtask

  task automatic test_single();
    int e = errors;
    start_test();
    wait_frame();
    write_packet(line_t'(2), pos_t'(20), 32);
    wait_blank(line_t'(3));
    check_output(0);
    end_test("single packet", e);
  endtask

  task automatic test_back_to_back();
    int e = errors;
    start_test();
    wait_frame();
    write_packet(line_t'(3), pos_t'(10), 32);
    write_packet(line_t'(3), pos_t'(42), 32);
    wait_blank(line_t'(4));
    check_output(0);
    end_test("back-to-back packets", e);
  endtask

  task automatic test_stale();
    int e = errors;
    start_test();
    wait_frame();
    wait_blank(line_t'(3));
    write_packet(line_t'(1), pos_t'(20), 32);
    exp_q.delete();  // Stale words never reach ade
    write_packet(line_t'(5), pos_t'(30), 32);
    wait_blank(line_t'(6));
    check_output(32);
    end_test("stale discard", e);
  endtask

  task automatic test_multi_line();
    int e = errors;
    start_test();
    wait_frame();
    write_packet(line_t'(1), pos_t'(15), 32);
    write_packet(line_t'(4), pos_t'(25), 32);
    wait_blank(line_t'(2));  // Line 1 packet has left the FIFO
    write_packet(line_t'(6), pos_t'(35), 32);
    wait_blank(line_t'(7));
    wait_frame();
    write_packet(line_t'(0), pos_t'(150), 32);  // Lands in vertical blanking
    wait_blank(line_t'(1));
    check_output(0);
    end_test("multiple lines and frame wrap", e);
  endtask

  task automatic test_underrun();
    int e = errors;
    start_test();
    wait_frame();
    write_packet(line_t'(2), pos_t'(40), 20);
    for (int i = 20; i < 32; i++)
      exp_q.push_back('{line: line_t'(2), pos: pos_t'(40 + i), sym: '0});
    wait_blank(line_t'(3));
    check_output(12);
    end_test("underrun", e);
  endtask

  task automatic test_full();
    int e = errors;
    start_test();
    wait_frame();
    write_packet(line_t'(5), pos_t'(10), 32);
    write_packet(line_t'(5), pos_t'(42), 32);
    for (int i = 0; i < 6; i++) begin
      @(posedge pclk);
      #1;
      if (full !== 1'b1) begin
        $display("MISMATCH full: expected %h got %h", 1'b1, full);
        errors++;
      end
      wr_en = 1'b1;
      wr_word = '{line: line_t'(5), start: pos_t'(74), sym: sym_t'($random(seed))};
    end
    @(posedge pclk);
    #1;
    wr_en = 1'b0;
    wait_blank(line_t'(6));
    check_output(0);
    end_test("FIFO full", e);
  endtask

  initial begin
    pclk = 1'b0;
    rst = 1'b1;
    vde = 1'b0;
    frame_start = 1'b0;
    wr_en = 1'b0;
    wr_word = '0;
    seed = 32'h310589d9;
    errors = 0;
    tests = 0;
    failed = 0;
    drop_cnt = 0;
    cycle_cnt = 0;
    repeat (16) @(posedge pclk);
    #1;
    rst = 1'b0;
    fork
      video_loop();
    join_none
    test_single();
    test_back_to_back();
    test_stale();
    test_multi_line();
    test_underrun();
    test_full();
    $display("Tests: %0d, failed: %0d, errors: %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/video_timing_pkg.sv
logic/aux_pkt_pkg.sv
logic/blank_tracker.sv
logic/aux_fifo.sv
logic/aux_scheduler.sv
logic/island_out.sv
logic/aux_island_top.sv
sim/aux_island_assertions.sv
sim/aux_island_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = aux_island_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
